/* mem_stage.f */
riscv_pkg.sv
mem_bus_pkg.sv
latency_timer.sv
data_ram.sv
mem_stage_fsm.sv
amo_alu.sv
result_formatter.sv
mem_stage_top.sv
tb_mem_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the memory stage testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --top-module tb_mem_stage -f mem_stage.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_mem_stage > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF '*** TEST PASSED ***' "$log"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $log"
    exit 1
fi

/* tb_mem_stage.sv */
module tb_mem_stage;
    timeunit 1ns;
    timeprecision 100ps;

    import riscv_pkg::*;
    import mem_bus_pkg::*;

    logic       clk;
    logic       reset;
    logic       valid;
    logic       is_new;
    mem_ctrl_t  ctrl;
    addr_t      alu_out;
    uint_x_t    rs2_data;
    trap_info_t trapinfo;
    trap_info_t next_trapinfo;
    uint_x_t    next_mem_rdata;
    logic       is_stall;

    logic [31:0] lfsr_state;
    uint_x_t     ref_mem [DMEM_WORDS];  // expected memory contents

    mem_stage_top mem_stage_top_inst (
        .clk            (clk),
        .reset          (reset),
        .valid          (valid),
        .is_new         (is_new),
        .ctrl           (ctrl),
        .alu_out        (alu_out),
        .rs2_data       (rs2_data),
        .trapinfo       (trapinfo),
        .next_trapinfo  (next_trapinfo),
        .next_mem_rdata (next_mem_rdata),
        .is_stall       (is_stall)
    );

    always #20 clk = ~clk;

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input uint_x_t got, input uint_x_t exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                    $time, what, got, exp));
        end
    endtask

    task automatic check_trap(input trap_info_t got, input trap_info_t exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s got %b/%0d expected %b/%0d",
                                    $time, what, got.valid, got.cause, exp.valid, exp.cause));
        end
    endtask

    task automatic check_stall(input bit got, input bit exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                                    $time, what, got, exp));
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic uint_x_t rand_bits(int n);
        uint_x_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[XLEN-2:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic mem_ctrl_t make_ctrl(mem_sel_t sel, mem_size_t sz, sign_sel_t sg,
                                            aext_sel_t a);
        mem_ctrl_t c;
        c.mem_wen  = sel;
        c.mem_size = sz;
        c.sign_sel = sg;
        c.a_sel    = a;
        return c;
    endfunction

    function automatic trap_info_t make_trap(logic v, trap_cause_t cause);
        trap_info_t t;
        t.valid = v;
        t.cause = cause;
        return t;
    endfunction

    function automatic int word_index(addr_t a);
        return int'(a[DMEM_IDX_BITS+1:2]);
    endfunction

    function automatic int byte_count(mem_size_t sz);
        case (sz)
            SIZE_B:  return 1;
            SIZE_H:  return 2;
            default: return 4;
        endcase
    endfunction

    function automatic void ref_store(addr_t a, uint_x_t d, mem_size_t sz);
        int idx;
        int lane;
        idx  = word_index(a);
        lane = int'(a[1:0]);
        for (int b = 0; b < byte_count(sz); b++) begin
            ref_mem[idx][(lane + b) * 8 +: 8] = d[b * 8 +: 8];
        end
    endfunction

    function automatic uint_x_t ref_load(addr_t a, mem_size_t sz, sign_sel_t sg);
        uint_x_t w;
        int      n;
        int      lane;
        logic    fill;
        w    = '0;
        n    = byte_count(sz);
        lane = int'(a[1:0]);
        for (int b = 0; b < n; b++) begin
            w[b * 8 +: 8] = ref_mem[word_index(a)][(lane + b) * 8 +: 8];
        end
        fill = (sg == OP_SIGNED) && w[n * 8 - 1];
        for (int b = n; b < 4; b++) begin
            w[b * 8 +: 8] = {8{fill}};
        end
        return w;
    endfunction

    function automatic uint_x_t amo_expect(aext_sel_t op, sign_sel_t sg, uint_x_t m,
                                           uint_x_t r);
        logic m_below;  // memory operand is the smaller one
        m_below = (sg == OP_SIGNED) ? ($signed(m) < $signed(r)) : (m < r);
        case (op)
            ASEL_AMO_SWAP: return r;
            ASEL_AMO_ADD:  return m + r;
            ASEL_AMO_XOR:  return m ^ r;
            ASEL_AMO_AND:  return m & r;
            ASEL_AMO_OR:   return m | r;
            ASEL_AMO_MIN:  return m_below ? m : r;
            default:       return m_below ? r : m;
        endcase
    endfunction

    // starts on a falling edge, returns on the falling edge where results are valid
    task automatic run_op(input mem_ctrl_t c, input addr_t a, input uint_x_t d,
                          output bit stalled);
        int cycles;
        cycles   = 0;
        ctrl     = c;
        alu_out  = a;
        rs2_data = d;
        valid    = 1'b1;
        is_new   = 1'b1;
        @(negedge clk);
        stalled = is_stall;
        is_new  = 1'b0;
        @(negedge clk);
        while (is_stall) begin
            stalled = 1'b1;
            cycles++;
            if (cycles > 200) begin
                stop_on_error($sformatf("timeout: is_stall high for 200 cycles, op at %h",
                                        a));
            end
            @(negedge clk);
        end
    endtask

    task automatic run_checked(input mem_ctrl_t c, input addr_t a, input uint_x_t d,
                               input uint_x_t exp, input string what);
        bit stalled;
        run_op(c, a, d, stalled);
        check_stall(stalled, 1'b1, {what, " stall"});
        check_word(next_mem_rdata, exp, what);
        check_trap(next_trapinfo, make_trap(1'b0, '0), what);
    endtask

    task automatic do_store(input addr_t a, input uint_x_t d, input mem_size_t sz);
        bit stalled;
        run_op(make_ctrl(MEN_S, sz, OP_SIGNED, ASEL_LR), a, d, stalled);
        check_trap(next_trapinfo, make_trap(1'b0, '0), $sformatf("store at %h", a));
        ref_store(a, d, sz);
    endtask

    task automatic do_load(input addr_t a, input mem_size_t sz, input sign_sel_t sg);
        run_checked(make_ctrl(MEN_L, sz, sg, ASEL_LR), a, '0, ref_load(a, sz, sg),
                    $sformatf("%s %s load at %h", sz.name(), sg.name(), a));
    endtask

    task automatic expect_fault(input mem_ctrl_t c, input addr_t a, input trap_cause_t cause,
                                input string what);
        bit stalled;
        run_op(c, a, rand_bits(32), stalled);
        check_trap(next_trapinfo, make_trap(1'b1, cause), $sformatf("%s at %h", what, a));
    endtask

    task automatic test_idle_passthrough();
        trap_info_t t;
        bit         stalled;
        check_stall(is_stall, 1'b0, "is_stall after reset");
        ctrl = make_ctrl(MEN_L, SIZE_W, OP_SIGNED, ASEL_LR);
        @(negedge clk);
        check_stall(is_stall, 1'b0, "is_stall with valid low");
        t = make_trap(1'b1, rand_bits(32));
        trapinfo = t;
        run_op(make_ctrl(MEN_X, SIZE_W, OP_SIGNED, ASEL_LR), '0, '0, stalled);
        check_stall(stalled, 1'b0, "MEN_X stall");
        check_trap(next_trapinfo, t, "MEN_X trapinfo");
        // left set, memory ops must not pass it through
    endtask

    task automatic test_load_store();
        addr_t base;
        for (int i = 0; i < 6; i++) begin
            base = rand_bits(DMEM_IDX_BITS) << 2;
            do_store(base, rand_bits(32), SIZE_W);
            do_load(base, SIZE_W, OP_SIGNED);
            for (int lane = 0; lane < 4; lane++) begin
                do_load(base | addr_t'(lane), SIZE_B, OP_SIGNED);
                do_load(base | addr_t'(lane), SIZE_B, OP_UNSIGNED);
                if (lane % 2 == 0) begin
                    do_load(base | addr_t'(lane), SIZE_H, OP_SIGNED);
                    do_load(base | addr_t'(lane), SIZE_H, OP_UNSIGNED);
                end
            end
            do_store(base | rand_bits(2), rand_bits(32), SIZE_B);  // upper data bits ignored
            do_load(base, SIZE_W, OP_UNSIGNED);
            do_store(base | (rand_bits(1) << 1), rand_bits(32), SIZE_H);
            do_load(base, SIZE_W, OP_UNSIGNED);
        end
    endtask

    task automatic test_lr_sc();
        addr_t   a;
        addr_t   b;
        uint_x_t d;
        a = rand_bits(DMEM_IDX_BITS) << 2;
        b = addr_t'(((word_index(a) + 1) % DMEM_WORDS) * 4);
        do_store(a, rand_bits(32), SIZE_W);
        do_store(b, rand_bits(32), SIZE_W);
        run_checked(make_ctrl(MEN_A, SIZE_W, OP_SIGNED, ASEL_LR), a, '0,
                    ref_load(a, SIZE_W, OP_SIGNED), "LR");
        d = rand_bits(32);
        run_checked(make_ctrl(MEN_A, SIZE_W, OP_SIGNED, ASEL_SC), a, d, 32'd0, "SC after LR");
        ref_store(a, d, SIZE_W);
        do_load(a, SIZE_W, OP_SIGNED);
        run_checked(make_ctrl(MEN_A, SIZE_W, OP_SIGNED, ASEL_SC), a, rand_bits(32), 32'd1,
                    "second SC");
        do_load(a, SIZE_W, OP_SIGNED);
        run_checked(make_ctrl(MEN_A, SIZE_W, OP_SIGNED, ASEL_LR), a, '0,
                    ref_load(a, SIZE_W, OP_SIGNED), "LR again");
        run_checked(make_ctrl(MEN_A, SIZE_W, OP_SIGNED, ASEL_SC), b, rand_bits(32), 32'd1,
                    "SC to another address");
        do_load(b, SIZE_W, OP_SIGNED);
    endtask

    task automatic test_amo();
        aext_sel_t ops [7] = '{ASEL_AMO_SWAP, ASEL_AMO_ADD, ASEL_AMO_XOR, ASEL_AMO_AND,
                               ASEL_AMO_OR, ASEL_AMO_MIN, ASEL_AMO_MAX};
        addr_t     a;
        uint_x_t   old;
        uint_x_t   r;
        sign_sel_t sg;
        for (int round = 0; round < 2; round++) begin
            foreach (ops[k]) begin
                for (int s = 0; s < 2; s++) begin
                    if (s == 0 || ops[k] == ASEL_AMO_MIN || ops[k] == ASEL_AMO_MAX) begin
                        sg  = sign_sel_t'(s[0]);
                        a   = rand_bits(DMEM_IDX_BITS) << 2;
                        old = rand_bits(32);
                        r   = rand_bits(32);
                        if (round == 1) begin
                            old = old | 32'h8000_0000;  // signs differ
                            r   = r & 32'h7fff_ffff;
                        end
                        do_store(a, old, SIZE_W);
                        run_checked(make_ctrl(MEN_A, SIZE_W, sg, ops[k]), a, r, old,
                                    $sformatf("%s %s", ops[k].name(), sg.name()));
                        ref_store(a, amo_expect(ops[k], sg, old, r), SIZE_W);
                        do_load(a, SIZE_W, OP_SIGNED);
                    end
                end
            end
        end
    endtask

    task automatic test_faults();
        addr_t       a;
        addr_t       alias_a;
        trap_cause_t ld_cause;
        trap_cause_t st_cause;
        for (int kind = 0; kind < 2; kind++) begin
            if (kind == 0) begin
                a        = DMEM_BYTES + (rand_bits(20) << 2);
                ld_cause = CAUSE_LOAD_ACCESS_FAULT;
                st_cause = CAUSE_STORE_AMO_ACCESS_FAULT;
            end else begin
                a        = 32'h8000_0000 | (rand_bits(29) << 2);
                ld_cause = CAUSE_LOAD_PAGE_FAULT;
                st_cause = CAUSE_STORE_AMO_PAGE_FAULT;
            end
            alias_a = addr_t'(word_index(a) * 4);  // same low index bits
            do_store(alias_a, rand_bits(32), SIZE_W);
            expect_fault(make_ctrl(MEN_L, SIZE_W, OP_SIGNED, ASEL_LR), a, ld_cause, "load");
            expect_fault(make_ctrl(MEN_A, SIZE_W, OP_SIGNED, ASEL_LR), a, ld_cause, "LR");
            expect_fault(make_ctrl(MEN_A, SIZE_W, OP_SIGNED, ASEL_SC), a, st_cause, "SC");
            expect_fault(make_ctrl(MEN_S, SIZE_W, OP_SIGNED, ASEL_LR), a, st_cause, "store");
            expect_fault(make_ctrl(MEN_A, SIZE_W, OP_SIGNED, ASEL_AMO_ADD), a, st_cause, "AMO");
            do_load(alias_a, SIZE_W, OP_SIGNED);
        end
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        valid      = 1'b0;
        is_new     = 1'b0;
        ctrl       = '0;
        alu_out    = '0;
        rs2_data   = '0;
        trapinfo   = '0;
        lfsr_state = 32'd99251;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        test_idle_passthrough();
        test_load_store();
        test_lr_sc();
        test_amo();
        test_faults();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* mem_stage_top.sv */
module mem_stage_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  valid,
    input  logic                  is_new,
    input  riscv_pkg::mem_ctrl_t  ctrl,
    input  riscv_pkg::addr_t      alu_out,
    input  riscv_pkg::uint_x_t    rs2_data,
    input  riscv_pkg::trap_info_t trapinfo,
    output riscv_pkg::trap_info_t next_trapinfo,
    output riscv_pkg::uint_x_t    next_mem_rdata,
    output logic                  is_stall
);
    import riscv_pkg::*;
    import mem_bus_pkg::*;

    d_req_t      dreq;
    d_resp_t     dresp;
    logic        ready;
    uint_x_t     amo_wdata;
    uint_x_t     saved_rdata;
    logic        sc_succeeded;
    logic        resp_error;
    fault_kind_t resp_errty;

    mem_stage_fsm fsm_inst (
        .clk          (clk),
        .reset        (reset),
        .valid        (valid),
        .is_new       (is_new),
        .ctrl         (ctrl),
        .alu_out      (alu_out),
        .rs2_data     (rs2_data),
        .amo_wdata    (amo_wdata),
        .ready        (ready),
        .dresp        (dresp),
        .dreq         (dreq),
        .saved_rdata  (saved_rdata),
        .sc_succeeded (sc_succeeded),
        .resp_error   (resp_error),
        .resp_errty   (resp_errty),
        .is_stall     (is_stall)
    );

    amo_alu amo_alu_inst (
        .ctrl      (ctrl),
        .mem_rdata (saved_rdata),
        .rs2_data  (rs2_data),
        .amo_wdata (amo_wdata)
    );

    result_formatter formatter_inst (
        .ctrl           (ctrl),
        .saved_rdata    (saved_rdata),
        .sc_succeeded   (sc_succeeded),
        .resp_error     (resp_error),
        .resp_errty     (resp_errty),
        .trapinfo       (trapinfo),
        .next_mem_rdata (next_mem_rdata),
        .next_trapinfo  (next_trapinfo)
    );

    data_ram ram_inst (
        .clk   (clk),
        .reset (reset),
        .dreq  (dreq),
        .ready (ready),
        .dresp (dresp)
    );

endmodule

/* result_formatter.sv */
module result_formatter (
    input  riscv_pkg::mem_ctrl_t     ctrl,
    input  riscv_pkg::uint_x_t       saved_rdata,
    input  logic                     sc_succeeded,
    input  logic                     resp_error,
    input  mem_bus_pkg::fault_kind_t resp_errty,
    input  riscv_pkg::trap_info_t    trapinfo,
    output riscv_pkg::uint_x_t       next_mem_rdata,
    output riscv_pkg::trap_info_t    next_trapinfo
);
    import riscv_pkg::*;
    import mem_bus_pkg::*;

    logic store_class;  // sc and amo fault as stores

    assign store_class = (ctrl.mem_wen == MEN_S) |
                         (ctrl.mem_wen == MEN_A & ctrl.a_sel != ASEL_LR);

    always_comb begin
        if (ctrl.mem_wen == MEN_A) begin
            if (ctrl.a_sel == ASEL_SC) begin
                next_mem_rdata = sc_succeeded ? '0 : uint_x_t'(1);
            end else begin
                next_mem_rdata = saved_rdata;  // old word for lr and amo
            end
        end else begin
            case (ctrl.mem_size)
                SIZE_B: begin
                    next_mem_rdata = {{24{ctrl.sign_sel == OP_SIGNED & saved_rdata[7]}},
                                      saved_rdata[7:0]};
                end
                SIZE_H: begin
                    next_mem_rdata = {{16{ctrl.sign_sel == OP_SIGNED & saved_rdata[15]}},
                                      saved_rdata[15:0]};
                end
                default: next_mem_rdata = saved_rdata;
            endcase
        end
    end

    always_comb begin
        if (ctrl.mem_wen == MEN_X) begin
            next_trapinfo = trapinfo;
        end else begin
            next_trapinfo.valid = resp_error;
            if (!resp_error) begin
                next_trapinfo.cause = '0;
            end else if (resp_errty == FE_PAGE_FAULT) begin
                next_trapinfo.cause = store_class ? CAUSE_STORE_AMO_PAGE_FAULT
                                                  : CAUSE_LOAD_PAGE_FAULT;
            end else begin
                next_trapinfo.cause = store_class ? CAUSE_STORE_AMO_ACCESS_FAULT
                                                  : CAUSE_LOAD_ACCESS_FAULT;
            end
        end
    end

endmodule

/* amo_alu.sv */
module amo_alu (
    input  riscv_pkg::mem_ctrl_t ctrl,
    input  riscv_pkg::uint_x_t   mem_rdata,
    input  riscv_pkg::uint_x_t   rs2_data,
    output riscv_pkg::uint_x_t   amo_wdata
);
    import riscv_pkg::*;

    logic mem_lt;  // memory word below rs2

    assign mem_lt = (ctrl.sign_sel == OP_SIGNED) ? ($signed(mem_rdata) < $signed(rs2_data))
                                                 : (mem_rdata < rs2_data);

    always_comb begin
        amo_wdata = '0;
        if (ctrl.mem_wen == MEN_A) begin
            case (ctrl.a_sel)
                ASEL_AMO_SWAP: amo_wdata = rs2_data;
                ASEL_AMO_ADD:  amo_wdata = mem_rdata + rs2_data;
                ASEL_AMO_XOR:  amo_wdata = mem_rdata ^ rs2_data;
                ASEL_AMO_AND:  amo_wdata = mem_rdata & rs2_data;
                ASEL_AMO_OR:   amo_wdata = mem_rdata | rs2_data;
                ASEL_AMO_MIN:  amo_wdata = mem_lt ? mem_rdata : rs2_data;
                ASEL_AMO_MAX:  amo_wdata = mem_lt ? rs2_data : mem_rdata;
                default:       amo_wdata = '0;  // lr, sc
            endcase
        end
    end

endmodule

/* mem_stage_fsm.sv */
module mem_stage_fsm (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     valid,
    input  logic                     is_new,
    input  riscv_pkg::mem_ctrl_t     ctrl,
    input  riscv_pkg::addr_t         alu_out,
    input  riscv_pkg::uint_x_t       rs2_data,
    input  riscv_pkg::uint_x_t       amo_wdata,
    input  logic                     ready,
    input  mem_bus_pkg::d_resp_t     dresp,
    output mem_bus_pkg::d_req_t      dreq,
    output riscv_pkg::uint_x_t       saved_rdata,
    output logic                     sc_succeeded,
    output logic                     resp_error,
    output mem_bus_pkg::fault_kind_t resp_errty,
    output logic                     is_stall
);
    import riscv_pkg::*;
    import mem_bus_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_READY,
        WAIT_RVALID,
        WAIT_WVALID
    } state_t;

    state_t   state;
    logic     executed;
    mem_sel_t replace_op;
    logic     reserve_valid;
    addr_t    reserve_addr;
    logic     is_done;
    mem_sel_t op;
    logic     is_store;
    logic     is_amo;

    assign is_done = executed & ~is_new;  // is_new starts a fresh instruction
    assign op = is_done ? MEN_X : (state != IDLE ? replace_op : ctrl.mem_wen);
    assign is_store = (op == MEN_S) | (op == MEN_A & ctrl.a_sel == ASEL_SC);
    assign is_amo = ctrl.a_sel != ASEL_LR & ctrl.a_sel != ASEL_SC;

    assign dreq.valid = (state == WAIT_READY) & valid & (op != MEN_X);
    assign dreq.wen   = is_store;
    assign dreq.addr  = alu_out;
    assign dreq.wdata = (ctrl.mem_wen == MEN_A & is_amo) ? amo_wdata : rs2_data;
    assign dreq.wmask = ctrl.mem_size;

    assign is_stall = valid & ((state != IDLE) | (op != MEN_X));

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= IDLE;
            executed      <= 1'b0;
            replace_op    <= MEN_X;
            reserve_valid <= 1'b0;
            sc_succeeded  <= 1'b0;
            resp_error    <= 1'b0;
        end else if (!valid || op == MEN_X) begin
            state      <= IDLE;
            replace_op <= MEN_X;
            if (!valid || is_new) begin
                executed <= 1'b0;
            end
        end else begin
            case (state)
                IDLE: begin
                    replace_op <= op;
                    executed   <= 1'b0;
                    resp_error <= 1'b0;
                    state      <= WAIT_READY;
                    if (op == MEN_A) begin
                        case (ctrl.a_sel)
                            ASEL_SC: begin
                                if (reserve_valid && reserve_addr == alu_out) begin
                                    sc_succeeded <= 1'b1;
                                end else begin
                                    // no reservation, finish without touching memory
                                    state        <= IDLE;
                                    replace_op   <= MEN_X;
                                    sc_succeeded <= 1'b0;
                                    executed     <= 1'b1;
                                end
                                reserve_valid <= 1'b0;
                            end
                            ASEL_LR: begin
                                reserve_addr  <= alu_out;
                                reserve_valid <= 1'b1;
                            end
                            default: ;
                        endcase
                    end
                end
                WAIT_READY: begin
                    if (ready) begin
                        state <= is_store ? WAIT_WVALID : WAIT_RVALID;
                    end
                end
                WAIT_RVALID: begin
                    if (dresp.valid) begin
                        saved_rdata <= dresp.rdata;
                        resp_error  <= dresp.error;
                        resp_errty  <= dresp.errty;
                        if (op == MEN_A && is_amo && !dresp.error) begin
                            state      <= WAIT_READY;  // write half of the amo
                            replace_op <= MEN_S;
                        end else begin
                            state      <= IDLE;
                            replace_op <= MEN_X;
                            executed   <= 1'b1;
                        end
                    end
                end
                WAIT_WVALID: begin
                    if (dresp.valid) begin
                        resp_error <= dresp.error;
                        resp_errty <= dresp.errty;
                        state      <= IDLE;
                        replace_op <= MEN_X;
                        executed   <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* data_ram.sv */
module data_ram (
    input  logic                 clk,
    input  logic                 reset,
    input  mem_bus_pkg::d_req_t  dreq,
    output logic                 ready,
    output mem_bus_pkg::d_resp_t dresp
);
    import riscv_pkg::*;
    import mem_bus_pkg::*;

    uint_x_t     mem [DMEM_WORDS];
    addr_t       addr_q;
    logic        wen_q;
    uint_x_t     wdata_q;
    mem_size_t   size_q;
    logic        fault_q;
    fault_kind_t kind_q;
    logic        busy;
    logic        done;
    logic        accept;
    logic [DMEM_IDX_BITS-1:0] idx;
    logic [4:0]  shift;
    uint_x_t     size_mask;

    assign ready  = ~busy;
    assign accept = dreq.valid & ready;

    latency_timer timer_inst (
        .clk   (clk),
        .reset (reset),
        .start (accept),
        .busy  (busy),
        .done  (done)
    );

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= dreq.addr;
            wen_q   <= dreq.wen;
            wdata_q <= dreq.wdata;
            size_q  <= dreq.wmask;
            fault_q <= dreq.addr[31] | (dreq.addr >= DMEM_BYTES);
            kind_q  <= dreq.addr[31] ? FE_PAGE_FAULT : FE_ACCESS_FAULT;
        end
    end

    assign idx   = addr_q[DMEM_IDX_BITS+1:2];
    assign shift = {addr_q[1:0], 3'b000};  // byte lane
    assign size_mask = (size_q == SIZE_B) ? uint_x_t'(32'h0000_00ff) :
                       (size_q == SIZE_H) ? uint_x_t'(32'h0000_ffff) : '1;

    always_ff @(posedge clk) begin
        if (done && wen_q && !fault_q) begin
            mem[idx] <= (mem[idx] & ~(size_mask << shift)) | ((wdata_q & size_mask) << shift);
        end
    end

    assign dresp.valid = done;
    assign dresp.error = done & fault_q;
    assign dresp.errty = kind_q;
    assign dresp.rdata = mem[idx] >> shift;

endmodule

/* latency_timer.sv */
module latency_timer (
    input  logic clk,
    input  logic reset,
    input  logic start,
    output logic busy,
    output logic done
);
    import mem_bus_pkg::*;

    logic [LAT_CNT_BITS-1:0] count;

    // covers the response cycle too, so no new request overlaps it
    assign busy = (count != '0) | done;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= (count == LAT_CNT_BITS'(1));
            if (start) begin
                count <= LAT_CNT_BITS'(MEM_LATENCY);
            end else if (count != '0) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* mem_bus_pkg.sv */
package mem_bus_pkg;

    typedef enum logic {
        FE_ACCESS_FAULT,
        FE_PAGE_FAULT
    } fault_kind_t;

    typedef struct packed {
        logic                  valid;
        logic                  wen;
        riscv_pkg::addr_t      addr;
        riscv_pkg::uint_x_t    wdata;
        riscv_pkg::mem_size_t  wmask;  // access size, lane from addr[1:0]
    } d_req_t;

    typedef struct packed {
        logic                  valid;
        logic                  error;
        fault_kind_t           errty;
        riscv_pkg::uint_x_t    rdata;
    } d_resp_t;

    localparam int DMEM_WORDS    = 1024;
    localparam int DMEM_IDX_BITS = $clog2(DMEM_WORDS);

    // bit 31 set is a page fault, otherwise anything past the array faults on access
    localparam logic [31:0] DMEM_BYTES = 32'(DMEM_WORDS * 4);

    // accept edge to response
    localparam int MEM_LATENCY  = 3;
    localparam int LAT_CNT_BITS = $clog2(MEM_LATENCY + 1);

endpackage

/* riscv_pkg.sv */
package riscv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] uint_x_t;
    typedef logic [31:0]     addr_t;

    typedef enum logic [1:0] {
        MEN_X,  // no memory access
        MEN_L,
        MEN_S,
        MEN_A
    } mem_sel_t;

    typedef enum logic [1:0] {
        SIZE_B,
        SIZE_H,
        SIZE_W
    } mem_size_t;

    typedef enum logic {
        OP_SIGNED,
        OP_UNSIGNED
    } sign_sel_t;

    typedef enum logic [3:0] {
        ASEL_LR,
        ASEL_SC,
        ASEL_AMO_SWAP,
        ASEL_AMO_ADD,
        ASEL_AMO_XOR,
        ASEL_AMO_AND,
        ASEL_AMO_OR,
        ASEL_AMO_MIN,
        ASEL_AMO_MAX
    } aext_sel_t;

    typedef struct packed {
        mem_sel_t  mem_wen;
        mem_size_t mem_size;
        sign_sel_t sign_sel;  // also picks signed min/max for amo
        aext_sel_t a_sel;
    } mem_ctrl_t;

    typedef logic [31:0] trap_cause_t;

    localparam trap_cause_t CAUSE_LOAD_ACCESS_FAULT      = 32'd5;
    localparam trap_cause_t CAUSE_STORE_AMO_ACCESS_FAULT = 32'd7;
    localparam trap_cause_t CAUSE_LOAD_PAGE_FAULT        = 32'd13;
    localparam trap_cause_t CAUSE_STORE_AMO_PAGE_FAULT   = 32'd15;

    typedef struct packed {
        logic        valid;
        trap_cause_t cause;
    } trap_info_t;

endpackage
